// File: Makefile
# Verilator build and run for the multiply unit testbench.

VERILATOR ?= verilator
TOP       ?= mul_unit_tb
BUILD_DIR ?= build
VFLAGS    ?= --binary -j 0

SOURCES := $(shell grep -v '^+' vlog.f) common/mul_macros.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source is newer than the binary.
$(BIN): vlog.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f vlog.f --top-module $(TOP) -Mdir $(BUILD_DIR)

# The run fails unless the output holds the pass line.
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(BUILD_DIR)

// File: common/mul_macros.svh
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// Operand and result width of the multiply unit.
`define MUL_XLEN 32

// Width of a destination register number (32 architectural registers).
`define MUL_REG_ADDR_W 5

// Width of the opcode field that selects mul.w, mulh.w or mulh.wu.
`define MUL_OP_W 2

`endif

// File: common/mul_pkg.sv
`include "mul_macros.svh"

// Shared types for the pipelined multiply unit.
package mul_pkg;

    // One operand, partial product or result word.
    typedef logic [`MUL_XLEN-1:0] mul_word_t;

    // Destination register number carried down the pipe.
    typedef logic [`MUL_REG_ADDR_W-1:0] mul_reg_addr_t;

    // Operation encoding seen at the unit input.
    // MUL_OP_W is the mul.w low product; the two others return the high word.
    typedef enum logic [`MUL_OP_W-1:0] {
        MUL_OP_W     = 2'd0, // Low 32 bits of the product.
        MUL_OP_MULH  = 2'd1, // Signed high 32 bits.
        MUL_OP_MULHU = 2'd2  // Unsigned high 32 bits.
    } mul_op_e;

    // The encoding 2'd3 is unused.
    // The issue stage treats it as a low product, like MUL_OP_W.

endpackage

// File: mul/mul_combine.sv
`timescale 1ns/1ps
`include "mul_macros.svh"

// Second arithmetic stage and write-back register.
// The four partials are summed into the 64-bit unsigned product and either
// the low word or the corrected high word is written back.
module mul_combine
    import mul_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          pp_valid,
    input  mul_reg_addr_t pp_rd,
    input  logic          pp_high,
    input  mul_word_t     pp_hh,
    input  mul_word_t     pp_hl,
    input  mul_word_t     pp_lh,
    input  mul_word_t     pp_ll,
    input  mul_word_t     pp_adj,
    output logic          wb_valid,
    output mul_reg_addr_t wb_rd,
    output mul_word_t     wb_result
);

    localparam int HALF = `MUL_XLEN / 2;

    logic [`MUL_XLEN:0]     mid_sum; // Both middle products, carry kept.
    logic [2*`MUL_XLEN-1:0] full;    // Unsigned 64-bit product.
    mul_word_t              sel;     // Word chosen for write-back.

    // The two middle products can overflow 32 bits, hence the extra bit.
    assign mid_sum = {1'b0, pp_hl} + {1'b0, pp_lh};

    // The outer products sit side by side. The middle sum is weighted by 2^16.
    assign full = {pp_hh, pp_ll} + {{(HALF-1){1'b0}}, mid_sum, {HALF{1'b0}}};

    // For mulh.w the correction turns the unsigned high word into the signed
    // one; for mulh.wu it is zero.
    always_comb begin
        if (pp_high) begin
            sel = full[2*`MUL_XLEN-1:`MUL_XLEN] + pp_adj;
        end else begin
            sel = full[`MUL_XLEN-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid  <= 1'b0;
            wb_rd     <= '0;
            wb_result <= '0;
        end else begin
            wb_valid  <= pp_valid;
            wb_rd     <= {`MUL_REG_ADDR_W{pp_valid}} & pp_rd;
            wb_result <= {`MUL_XLEN{pp_valid}} & sel; // Bubbles write back zero.
        end
    end

endmodule

// File: mul/mul_partial.sv
`timescale 1ns/1ps
`include "mul_macros.svh"

// First arithmetic stage.
// Each operand is split into 16-bit halves and the four unsigned cross
// products are formed. The signed correction for the high word is built here
// as well, from the two sign bits, so the next stage only has to add.
module mul_partial
    import mul_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          is_valid,
    input  mul_reg_addr_t is_rd,
    input  logic          is_high,
    input  logic          is_signed,
    input  mul_word_t     is_src0,
    input  mul_word_t     is_src1,
    output logic          pp_valid,
    output mul_reg_addr_t pp_rd,
    output logic          pp_high,
    output mul_word_t     pp_hh,
    output mul_word_t     pp_hl,
    output mul_word_t     pp_lh,
    output mul_word_t     pp_ll,
    output mul_word_t     pp_adj
);

    localparam int HALF = `MUL_XLEN / 2;

    logic [HALF-1:0] a_hi, a_lo; // Halves of src0.
    logic [HALF-1:0] b_hi, b_lo; // Halves of src1.
    mul_word_t       adj;        // Correction added to the unsigned high word.

    assign a_hi = is_src0[`MUL_XLEN-1:HALF];
    assign a_lo = is_src0[HALF-1:0];
    assign b_hi = is_src1[`MUL_XLEN-1:HALF];
    assign b_lo = is_src1[HALF-1:0];

    // Reading a negative operand as unsigned adds 2^32 times the other
    // operand to the product, so the high word is too large by that operand.
    // Subtracting it back gives the signed high word modulo 2^32.
    always_comb begin
        adj = '0;
        if (is_signed) begin
            case ({is_src0[`MUL_XLEN-1], is_src1[`MUL_XLEN-1]})
                2'b11:   adj = -(is_src0 + is_src1); // Both negative.
                2'b10:   adj = -is_src1;             // Only src0 negative.
                2'b01:   adj = -is_src0;             // Only src1 negative.
                default: adj = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pp_valid <= 1'b0;
            pp_rd    <= '0;
            pp_high  <= 1'b0;
            pp_hh    <= '0;
            pp_hl    <= '0;
            pp_lh    <= '0;
            pp_ll    <= '0;
            pp_adj   <= '0;
        end else begin
            pp_valid <= is_valid;
            pp_rd    <= {`MUL_REG_ADDR_W{is_valid}} & is_rd;
            pp_high  <= is_high;
            // A 16x16 product fits the 32-bit word exactly.
            pp_hh    <= mul_word_t'(a_hi) * mul_word_t'(b_hi);
            pp_hl    <= mul_word_t'(a_hi) * mul_word_t'(b_lo);
            pp_lh    <= mul_word_t'(a_lo) * mul_word_t'(b_hi);
            pp_ll    <= mul_word_t'(a_lo) * mul_word_t'(b_lo);
            pp_adj   <= adj;
        end
    end

endmodule

// File: rtl/mul_issue.sv
`timescale 1ns/1ps
`include "mul_macros.svh"

// Issue register of the multiply unit.
// It captures every incoming operation and turns the opcode into two flags
// that the arithmetic stages use directly.
module mul_issue
    import mul_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  mul_op_e       in_op,
    input  mul_reg_addr_t in_rd,
    input  mul_word_t     in_src0,
    input  mul_word_t     in_src1,
    output logic          is_valid,
    output mul_reg_addr_t is_rd,
    output logic          is_high,
    output logic          is_signed,
    output mul_word_t     is_src0,
    output mul_word_t     is_src1
);

    logic dec_high;   // High word requested.
    logic dec_signed; // Operands are treated as signed.

    // Opcode decode.
    // The signed flag only changes the high-word correction, so it has no
    // effect on mul.w whatever value it takes.
    always_comb begin
        dec_high   = (in_op == MUL_OP_MULH) || (in_op == MUL_OP_MULHU);
        dec_signed = (in_op == MUL_OP_MULH);
    end

    // The register loads on every edge, bubbles included.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_valid  <= 1'b0;
            is_rd     <= '0;
            is_high   <= 1'b0;
            is_signed <= 1'b0;
            is_src0   <= '0;
            is_src1   <= '0;
        end else begin
            is_valid  <= in_valid;
            is_rd     <= {`MUL_REG_ADDR_W{in_valid}} & in_rd; // A bubble carries rd 0.
            is_high   <= dec_high;
            is_signed <= dec_signed;
            is_src0   <= in_src0;
            is_src1   <= in_src1;
        end
    end

endmodule

// File: rtl/mul_unit.sv
`timescale 1ns/1ps
`include "mul_macros.svh"

// Pipelined 32-bit multiply unit for the execute stage.
// Issue, partial-product and combine registers give a fixed three-cycle
// latency, and one new operation can enter on every cycle.
module mul_unit
    import mul_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  mul_op_e       in_op,
    input  mul_reg_addr_t in_rd,
    input  mul_word_t     in_src0,
    input  mul_word_t     in_src1,
    output logic          wb_valid,
    output mul_reg_addr_t wb_rd,
    output mul_word_t     wb_result
);

    // Issue register outputs.
    logic          is_valid;
    mul_reg_addr_t is_rd;
    logic          is_high;
    logic          is_signed;
    mul_word_t     is_src0;
    mul_word_t     is_src1;

    // Partial-product register outputs.
    logic          pp_valid;
    mul_reg_addr_t pp_rd;
    logic          pp_high;
    mul_word_t     pp_hh;
    mul_word_t     pp_hl;
    mul_word_t     pp_lh;
    mul_word_t     pp_ll;
    mul_word_t     pp_adj;

    mul_issue u_issue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_rd     (in_rd),
        .in_src0   (in_src0),
        .in_src1   (in_src1),
        .is_valid  (is_valid),
        .is_rd     (is_rd),
        .is_high   (is_high),
        .is_signed (is_signed),
        .is_src0   (is_src0),
        .is_src1   (is_src1)
    );

    mul_partial u_partial (
        .clk       (clk),
        .rst_n     (rst_n),
        .is_valid  (is_valid),
        .is_rd     (is_rd),
        .is_high   (is_high),
        .is_signed (is_signed),
        .is_src0   (is_src0),
        .is_src1   (is_src1),
        .pp_valid  (pp_valid),
        .pp_rd     (pp_rd),
        .pp_high   (pp_high),
        .pp_hh     (pp_hh),
        .pp_hl     (pp_hl),
        .pp_lh     (pp_lh),
        .pp_ll     (pp_ll),
        .pp_adj    (pp_adj)
    );

    mul_combine u_combine (
        .clk       (clk),
        .rst_n     (rst_n),
        .pp_valid  (pp_valid),
        .pp_rd     (pp_rd),
        .pp_high   (pp_high),
        .pp_hh     (pp_hh),
        .pp_hl     (pp_hl),
        .pp_lh     (pp_lh),
        .pp_ll     (pp_ll),
        .pp_adj    (pp_adj),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_result (wb_result)
    );

endmodule

// File: verification/mul_golden.txt
# Columns: name, opcode (0 mul.w, 1 mulh.w, 2 mulh.wu), src0, src1, rd, expected result.
# Every value after the name is hex. Tests named b2b_ are issued on consecutive cycles.
mulw_small      0 00000003 00000007 01 00000015
mulw_ffff_sq    0 0000ffff 0000ffff 02 fffe0001
mulw_mid_carry  0 00010001 00010001 03 00020001
mulw_shift      0 12345678 00000010 04 23456780
mulw_neg_pos    0 fffffffd 00000007 05 ffffffeb
mulw_all_ones   0 ffffffff ffffffff 06 00000001
mulw_min_x2     0 80000000 00000002 07 00000000
mulhu_all_ones  2 ffffffff ffffffff 08 fffffffe
mulhu_min_sq    2 80000000 80000000 09 40000000
mulhu_mid_carry 2 00010001 00010001 0a 00000001
mulhu_hi_lo     2 ffff0000 0000ffff 0b 0000fffe
mulhu_small     2 00000003 00000007 0c 00000000
mulh_pos_pos    1 40000000 00000004 0d 00000001
mulh_max_sq     1 7fffffff 7fffffff 0e 3fffffff
mulh_neg_pos    1 80000000 00000004 0f fffffffe
mulh_pos_neg    1 7fffffff 80000000 10 c0000000
mulh_neg_neg    1 80000000 80000000 11 40000000
mulh_minus_one  1 ffffffff ffffffff 12 00000000
b2b_mulw        0 00000002 00000003 13 00000006
b2b_mulhu       2 ffffffff 00000002 14 00000001
b2b_mulh        1 fffffffe 00000003 15 ffffffff
b2b_mulw_neg    0 fffffffe 00000003 16 fffffffa
b2b_zero        1 00000000 12345678 1f 00000000

// File: verification/mul_unit_tb.sv
`timescale 1ns/1ps
`include "mul_macros.svh"

// Testbench for the pipelined multiply unit.
// Every operation and its expected write-back come from the golden file.
module mul_unit_tb
    import mul_pkg::*;
();

    localparam string GOLDEN_FILE = "verification/mul_golden.txt";
    localparam int    LATENCY     = 3; // Edges from acceptance to write-back.

    logic          clk = 1'b0;
    logic          rst_n;
    logic          in_valid;
    mul_op_e       in_op;
    mul_reg_addr_t in_rd;
    mul_word_t     in_src0;
    mul_word_t     in_src1;
    logic          wb_valid;
    mul_reg_addr_t wb_rd;
    mul_word_t     wb_result;

    // Golden table, one entry per test.
    string         names[$];
    logic [1:0]    ops[$];
    mul_word_t     src0s[$];
    mul_word_t     src1s[$];
    mul_reg_addr_t rds[$];
    mul_word_t     results[$];

    int   exp_idx_q[$];      // Tests in flight, oldest first.
    int   exp_edge_q[$];     // Edge at which each of them was accepted.
    int   cycle_count = 0;   // Rising edges seen so far.
    int   cycle_limit = 0;   // Zero until the golden file is loaded.
    int   load_errors = 0;
    int   mon_errors  = 0;
    int   leftover    = 0;
    int   pass_count  = 0;
    int   fail_count  = 0;
    int   done_count  = 0;
    int   mon_idx;
    int   mon_edge;
    logic mon_ok;
    logic idle_ok;
    int   gap;

    mul_unit u_mul_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_rd     (in_rd),
        .in_src0   (in_src0),
        .in_src1   (in_src1),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_result (wb_result)
    );

    always #5 clk = ~clk; // 10 ns period.

    // Edge counter and run limit.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d tests written back",
                     cycle_count, done_count, names.size());
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_word(input string name, input mul_word_t expected,
                              input mul_word_t actual, inout logic ok);
        if (actual !== expected) begin
            $display("CHECK FAILED %s result: expected %h, actual %h", name, expected, actual);
            ok = 1'b0;
        end
    endtask

    task automatic check_rd(input string name, input mul_reg_addr_t expected,
                            input mul_reg_addr_t actual, inout logic ok);
        if (actual !== expected) begin
            $display("CHECK FAILED %s rd: expected %h, actual %h", name, expected, actual);
            ok = 1'b0;
        end
    endtask

    // Tests named b2b_ are issued with no idle cycle before them.
    function automatic logic is_back_to_back(input string name);
        return name.len() >= 4 && name.substr(0, 3) == "b2b_";
    endfunction

    task automatic load_golden();
        int          fd;
        int          cnt;
        int          ch;
        string       tok;
        logic [31:0] f_op;
        logic [31:0] f_rd;
        mul_word_t   f_s0, f_s1, f_exp;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the golden file %s", GOLDEN_FILE);
            load_errors++;
            return;
        end
        while (!$feof(fd)) begin
            cnt = $fscanf(fd, "%s", tok);
            if (cnt == 1) begin
                if (tok.substr(0, 0) == "#") begin
                    ch = $fgetc(fd); // Skip the rest of a comment line.
                    while (ch != 10 && ch != -1) ch = $fgetc(fd);
                end else begin
                    cnt = $fscanf(fd, "%h %h %h %h %h", f_op, f_s0, f_s1, f_rd, f_exp);
                    if (cnt == 5) begin
                        names.push_back(tok);
                        ops.push_back(f_op[1:0]);
                        src0s.push_back(f_s0);
                        src1s.push_back(f_s1);
                        rds.push_back(f_rd[`MUL_REG_ADDR_W-1:0]);
                        results.push_back(f_exp);
                    end else begin
                        $display("Golden line for %s has missing fields", tok);
                        load_errors++;
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_op(input int idx);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_op    = mul_op_e'(ops[idx]);
        in_rd    = rds[idx];
        in_src0  = src0s[idx];
        in_src1  = src1s[idx];
        exp_idx_q.push_back(idx);
        exp_edge_q.push_back(cycle_count + 1); // Accepted at the coming edge.
    endtask

    // Idle cycle with random data on the inputs, which must not leak out.
    task automatic drive_bubble();
        logic [1:0] rnd_op;
        @(posedge clk);
        #1;
        rnd_op   = 2'($urandom_range(0, 2));
        in_valid = 1'b0;
        in_op    = mul_op_e'(rnd_op);
        in_rd    = mul_reg_addr_t'($urandom);
        in_src0  = $urandom;
        in_src1  = $urandom;
    endtask

    // Outputs settle after the rising edge, so they are sampled on the falling one.
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            if (exp_idx_q.size() == 0) begin
                $display("A write-back to rd %0d arrived with no operation in flight", wb_rd);
                mon_errors++;
            end else begin
                mon_idx  = exp_idx_q.pop_front();
                mon_edge = exp_edge_q.pop_front();
                mon_ok   = 1'b1;
                check_word(names[mon_idx], results[mon_idx], wb_result, mon_ok);
                check_rd(names[mon_idx], rds[mon_idx], wb_rd, mon_ok);
                // The write-back seen here is captured at the next rising edge.
                if (cycle_count + 1 != mon_edge + LATENCY) begin
                    $display("%s was written back at edge %0d, expected at edge %0d",
                             names[mon_idx], cycle_count + 1, mon_edge + LATENCY);
                    mon_ok = 1'b0;
                end
                if (mon_ok) begin
                    pass_count++;
                    $display("%-16s ok", names[mon_idx]);
                end else begin
                    fail_count++;
                    $display("%-16s failed", names[mon_idx]);
                end
                done_count++;
            end
        end else if (rst_n) begin
            idle_ok = 1'b1; // No write-back, so both fields must read zero.
            check_word("idle", '0, wb_result, idle_ok);
            check_rd("idle", '0, wb_rd, idle_ok);
            if (!idle_ok) mon_errors++;
        end
    end

    initial begin
        void'($urandom(32'h39e03c9c));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_op    = MUL_OP_W;
        in_rd    = '0;
        in_src0  = '0;
        in_src1  = '0;
        load_golden();
        cycle_limit = 4 * names.size() + 50;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) drive_bubble(); // Quiet outputs before the first issue.
        for (int i = 0; i < names.size(); i++) begin
            if (!is_back_to_back(names[i])) begin
                gap = $urandom_range(0, 2);
                repeat (gap) drive_bubble();
            end
            drive_op(i);
        end
        while (done_count < names.size()) drive_bubble();
        repeat (4) drive_bubble(); // Nothing more may come out.
        if (exp_idx_q.size() != 0) begin
            $display("%0d operations were never written back", exp_idx_q.size());
            leftover = exp_idx_q.size();
        end
        $display("Summary: %0d passed, %0d failed, %0d other errors",
                 pass_count, fail_count, load_errors + mon_errors + leftover);
        if (fail_count == 0 && load_errors + mon_errors + leftover == 0
                && names.size() > 0 && pass_count == names.size()) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+common
common/mul_pkg.sv
rtl/mul_issue.sv
mul/mul_partial.sv
mul/mul_combine.sv
rtl/mul_unit.sv
verification/mul_unit_tb.sv
